// File: run_sim.sh
#!/bin/sh
# Build the mailbox testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f build.log sim_run.log

verilator --binary --timing --assert -Wno-fatal --top-module mbx_periph_tb \
    -f vlog.f --Mdir obj_dir -o mbx_periph_sim > build.log 2>&1 &&
    ./obj_dir/mbx_periph_sim > sim_run.log 2>&1 ||
    { echo "Build or simulation run failed"; tail -n 20 build.log sim_run.log; exit 1; }

grep -q "Result: FAILED" sim_run.log && { echo "Simulation FAILED"; exit 1; }
grep -q "Result: PASSED" sim_run.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"

// File: sim/mbx_periph_props.sv
`timescale 1ns/1ps

module mbx_periph_props #(
    parameter int DOUT_WORDS = 2
) (
    input  logic                                          seq,
    input  logic                                          rst_n_i,
    input  mbx_bus_pkg::bus_req_t                         bus_req_i,
    input  logic                                          gnt_o,
    input  mbx_bus_pkg::bus_rsp_t                         rsp_o,
    input  logic                                          rvalid_o,
    input  logic                                          rready_i,
    input  logic [DOUT_WORDS*mbx_cfg_pkg::DATA_WIDTH-1:0] dout_o,
    input  logic                                          dout_valid_o,
    input  logic                                          dout_ready_i
);

    assert property (@(posedge seq) disable iff (!rst_n_i) gnt_o |-> bus_req_i.req)
        else $error("gnt_o high without a bus request");

    // Held beats must not change while stalled
    assert property (@(posedge seq) disable iff (!rst_n_i)
        (rvalid_o && !rready_i) |=> (rvalid_o && $stable(rsp_o)))
        else $error("response beat changed or dropped under stall");

    assert property (@(posedge seq) disable iff (!rst_n_i)
        (dout_valid_o && !dout_ready_i) |=> (dout_valid_o && $stable(dout_o)))
        else $error("outbound frame changed or dropped under stall");

    assert property (@(posedge seq) !rst_n_i |=> (!rvalid_o && !dout_valid_o))
        else $error("valid output high during reset");

endmodule

bind mbx_periph mbx_periph_props #(
    .DOUT_WORDS (DOUT_WORDS)
) u_props (
    .seq          (seq),
    .rst_n_i      (rst_n_i),
    .bus_req_i    (bus_req_i),
    .gnt_o        (gnt_o),
    .rsp_o        (rsp_o),
    .rvalid_o     (rvalid_o),
    .rready_i     (rready_i),
    .dout_o       (dout_o),
    .dout_valid_o (dout_valid_o),
    .dout_ready_i (dout_ready_i)
);

// File: sim/mbx_periph_tb.sv
`timescale 1ns/1ps

module mbx_periph_tb;
    import mbx_cfg_pkg::*;
    import mbx_bus_pkg::*;

    localparam int DIN_WORDS  = 3;
    localparam int DOUT_WORDS = 2;

    // One trace record, word 0 in the low bits
    typedef struct packed {
        logic [7:0]                           kind;
        logic [7:0]                           arg;  // Index or din delay
        logic [DIN_WORDS-1:0][DATA_WIDTH-1:0] words;
    } op_t;

    logic                               seq;
    logic                               rst_n_i;
    bus_req_t                           bus_req;
    logic                               gnt_o;
    bus_rsp_t                           rsp_o;
    logic                               rvalid_o;
    logic                               rready_i;
    logic [DIN_WORDS*DATA_WIDTH-1:0]    din_i;
    logic                               din_valid_i;
    logic                               din_ready_o;
    logic [DOUT_WORDS*DATA_WIDTH-1:0]   dout_o;
    logic                               dout_valid_o;
    logic                               dout_ready_i;

    op_t                             ops[$];
    string                           names[$];        // Test name per record
    op_t                             din_jobs[$];
    data_t                           exp_rsp[$];
    string                           exp_rsp_test[$];
    logic [DOUT_WORDS*DATA_WIDTH-1:0] exp_dout[$];
    string                           exp_dout_test[$];

    string test_name = "reset";
    int    mism_cnt = 0;
    int    other_cnt = 0;
    int    trace_lines = 0;
    int    cycle_limit = 0;
    int    cycles = 0;
    int    reset_edges = 0;
    logic  held = 1'b0;                                 // Model of the inbound full flag
    logic  dout_pend = 1'b0;                            // Outbound frame not yet taken

    mbx_periph #(
        .DIN_WORDS  (DIN_WORDS),
        .DOUT_WORDS (DOUT_WORDS)
    ) UUT (
        .seq          (seq),
        .rst_n_i      (rst_n_i),
        .bus_req_i    (bus_req),
        .gnt_o        (gnt_o),
        .rsp_o        (rsp_o),
        .rvalid_o     (rvalid_o),
        .rready_i     (rready_i),
        .din_i        (din_i),
        .din_valid_i  (din_valid_i),
        .din_ready_o  (din_ready_o),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .dout_ready_i (dout_ready_i)
    );

    initial begin
        seq = 1'b0;
        forever #5 seq = ~seq;
    end

    // ----------------------------------------------------------------------
    // Trace loading
    // ----------------------------------------------------------------------
    task automatic load_trace();
        int    fd;
        int    n;
        int    i;
        int    num;
        string tok;
        string line;
        string cur_test;
        op_t   op;
        data_t w;
        logic [DOUT_WORDS*DATA_WIDTH-1:0] frame;
        fd = $fopen("sim/mbx_trace.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("cannot open trace file sim/mbx_trace.txt");
            return;
        end
        cur_test = "none";
        while ($fscanf(fd, "%s", tok) == 1) begin
            trace_lines++;
            op      = '0;
            op.kind = tok.getc(0);
            case (op.kind)
                "#": n = $fgets(line, fd);                  // Column notes
                "T": n = $fscanf(fd, "%s", cur_test);
                "D": begin
                    n = $fscanf(fd, "%d", num);
                    op.arg = 8'(num);
                    for (i = 0; i < DIN_WORDS; i++) begin
                        n = $fscanf(fd, "%h", w);
                        op.words[i] = w;
                    end
                end
                "R", "W": begin
                    n = $fscanf(fd, "%d %h", num, w);
                    op.arg      = 8'(num);
                    op.words[0] = w;
                    exp_rsp.push_back((op.kind == "W") ? '0 : w); // Writes answer zero
                    exp_rsp_test.push_back(cur_test);
                end
                "O": begin
                    for (i = 0; i < DOUT_WORDS; i++) begin
                        n = $fscanf(fd, "%h", w);
                        frame[i*DATA_WIDTH +: DATA_WIDTH] = w;
                    end
                    exp_dout.push_back(frame);
                    exp_dout_test.push_back(cur_test);
                end
                default: begin
                    other_cnt++;
                    $display("unknown trace record %s", tok);
                end
            endcase
            if (op.kind != "#") begin
                ops.push_back(op);
                names.push_back(cur_test);
            end
        end
        $fclose(fd);
    endtask

    // Called on a falling edge, returns on the falling edge after the grant
    task automatic bus_access(input logic we, input int idx, input data_t wdata);
        bus_req.req   = 1'b1;
        bus_req.we    = we;
        bus_req.addr  = addr_t'(idx) << BYTE_OFS;
        bus_req.wdata = wdata;
        @(posedge seq);
        while (!gnt_o) @(posedge seq);
        @(negedge seq);
        bus_req = '0;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus
    // ----------------------------------------------------------------------
    initial begin : stall_gen
        rready_i     = 1'b0;
        dout_ready_i = 1'b0;
        void'($urandom(32'hd50));
        forever begin
            @(negedge seq);
            rready_i     = ($urandom % 4) != 0;             // Low on about a quarter of cycles
            dout_ready_i = ($urandom % 4) != 0;
        end
    end

    initial begin : din_driver
        op_t job;
        din_i       = '0;
        din_valid_i = 1'b0;
        forever begin
            @(negedge seq);
            if (din_jobs.size() != 0) begin
                job = din_jobs.pop_front();
                repeat (int'(job.arg)) @(negedge seq);
                din_i       = job.words;
                din_valid_i = 1'b1;
                @(posedge seq);
                while (!din_ready_o) @(posedge seq);
                @(negedge seq);
                din_valid_i = 1'b0;
            end
        end
    end

    initial begin : main
        int k;
        rst_n_i = 1'b0;
        bus_req = '0;
        load_trace();
        cycle_limit = 20 * trace_lines + 200;
        repeat (8) @(posedge seq);
        @(negedge seq);
        rst_n_i = 1'b1;
        if (other_cnt == 0) begin
            for (k = 0; k < ops.size(); k++) begin
                test_name = names[k];
                case (ops[k].kind)
                    "D":     din_jobs.push_back(ops[k]);
                    "R":     bus_access(1'b0, int'(ops[k].arg), '0);
                    "W":     bus_access(1'b1, int'(ops[k].arg), ops[k].words[0]);
                    default: ;                              // Markers and frames already queued
                endcase
            end
            while (exp_rsp.size() != 0 || exp_dout.size() != 0 ||
                   din_jobs.size() != 0 || din_valid_i) begin
                @(negedge seq);
            end
            repeat (20) @(negedge seq);                     // Room for a stray frame
        end
        $display("errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // ----------------------------------------------------------------------
    // Reference model and checks
    // ----------------------------------------------------------------------
    always @(posedge seq) begin : monitor
        int    idx;
        data_t exp_word;
        logic [DOUT_WORDS*DATA_WIDTH-1:0] exp_frame;
        string tname;
        if (!rst_n_i) begin
            reset_edges++;
            if (reset_edges > 1) begin
                // Bits are gnt, rvalid, dout_valid, din_ready
                assert ({gnt_o, rvalid_o, dout_valid_o, din_ready_o} == 4'b0001) else begin
                    mism_cnt++;
                    $display("mismatch test %s reset outputs expected %b actual %b",
                             test_name, 4'b0001, {gnt_o, rvalid_o, dout_valid_o, din_ready_o});
                end
            end
        end else begin
            assert (din_ready_o == !held) else begin
                mism_cnt++;
                $display("mismatch test %s din_ready_o expected %b actual %b",
                         test_name, !held, din_ready_o);
            end
            if (bus_req.req && gnt_o) begin
                idx = int'(bus_req.addr >> BYTE_OFS);
                if (!bus_req.we) begin
                    assert (held) else begin
                        other_cnt++;
                        $display("test %s read granted while no inbound frame was held",
                                 test_name);
                    end
                    if (idx == DIN_WORDS - 1) held = 1'b0;
                end else begin
                    assert (!dout_pend) else begin
                        other_cnt++;
                        $display("test %s write granted before the outbound frame was taken",
                                 test_name);
                    end
                    if (idx == DOUT_WORDS - 1) dout_pend = 1'b1;
                end
            end
            if (din_valid_i && din_ready_o) held = 1'b1;
            if (rvalid_o && rready_i) begin
                if (exp_rsp.size() == 0) begin
                    other_cnt++;
                    $display("response beat arrived with no access outstanding");
                end else begin
                    exp_word = exp_rsp.pop_front();
                    tname    = exp_rsp_test.pop_front();
                    assert (rsp_o.rdata == exp_word) else begin
                        mism_cnt++;
                        $display("mismatch test %s rdata expected %h actual %h",
                                 tname, exp_word, rsp_o.rdata);
                    end
                end
            end
            if (dout_valid_o && dout_ready_i) begin
                dout_pend = 1'b0;
                if (exp_dout.size() == 0) begin
                    other_cnt++;
                    $display("outbound frame %h sent with none expected", dout_o);
                end else begin
                    exp_frame = exp_dout.pop_front();
                    tname     = exp_dout_test.pop_front();
                    assert (dout_o == exp_frame) else begin
                        mism_cnt++;
                        $display("mismatch test %s dout expected %h actual %h",
                                 tname, exp_frame, dout_o);
                    end
                end
            end
        end
    end

    always @(posedge seq) begin : watchdog
        cycles++;
        if (cycles >= cycle_limit) begin
            other_cnt++;
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
            $display("Result: FAILED");
            $finish;
        end
    end

endmodule

// File: sim/mbx_trace.txt
# One record per line, data words in hex, index and delay in decimal
# T name | D delay w0 w1 w2 | R idx expect | W idx data | O w0 w1 (word 0 first)
T reset_and_readout
D 0 11110000 22220001 33330002
R 0 11110000
R 1 22220001
R 2 33330002
T read_blocking
D 6 a5a50010 a5a50011 a5a50012
R 0 a5a50010
R 1 a5a50011
R 2 a5a50012
T outbound_assembly
W 0 deadbeef
W 1 cafef00d
O deadbeef cafef00d
T out_of_range
D 0 0badc0de 1badc0de 2badc0de
R 5 00000000
R 0 0badc0de
R 1 1badc0de
R 2 2badc0de
W 5 12345678
W 0 00c0ffee
W 1 01c0ffee
O 00c0ffee 01c0ffee
T back_pressure
D 0 b0000000 b0000001 b0000002
W 0 c0000000
R 0 b0000000
W 1 c0000001
R 1 b0000001
D 2 d0000000 d0000001 d0000002
O c0000000 c0000001
W 0 c0000010
R 2 b0000002
W 1 c0000011
O c0000010 c0000011
R 0 d0000000
R 1 d0000001
R 2 d0000002
W 0 e0000000
W 1 e0000001
O e0000000 e0000001

// File: verilog/bus_responder.sv
`timescale 1ns/1ps

module bus_responder (
    input  logic                   seq,
    input  logic                   rst_n_i,

    input  mbx_bus_pkg::bus_req_t  bus_req_i,
    output logic                   gnt_o,

    input  logic                   din_full_i,
    input  logic                   frame_busy_i,
    input  mbx_cfg_pkg::data_t     rd_word_i,

    output mbx_bus_pkg::word_acc_t rd_acc_o,
    output mbx_bus_pkg::word_acc_t wr_acc_o,

    output mbx_bus_pkg::bus_rsp_t  rsp_o,
    output logic                   rvalid_o,
    input  logic                   rready_i
);
    import mbx_cfg_pkg::*;
    import mbx_bus_pkg::*;

    addr_t word_addr;
    idx_t  idx;
    logic  target_ok;
    logic  rsp_ready;
    data_t rsp_in;
    data_t rsp_out;

    // ----------------------------------------------------------------------
    // Index decode
    // ----------------------------------------------------------------------
    assign word_addr = bus_req_i.addr >> BYTE_OFS;

    // Large word addresses saturate to 255, which no frame reaches
    assign idx = (|word_addr[ADDR_WIDTH-1:IDX_WIDTH]) ? '1 : word_addr[IDX_WIDTH-1:0];

    // ----------------------------------------------------------------------
    // Grant
    // ----------------------------------------------------------------------
    assign target_ok = bus_req_i.we ? !frame_busy_i : din_full_i;
    assign gnt_o     = bus_req_i.req && rsp_ready && target_ok;

    always_comb begin
        rd_acc_o.fire  = gnt_o && !bus_req_i.we;
        rd_acc_o.idx   = idx;
        rd_acc_o.wdata = '0;
        wr_acc_o.fire  = gnt_o && bus_req_i.we;
        wr_acc_o.idx   = idx;
        wr_acc_o.wdata = bus_req_i.wdata;
    end

    assign rsp_in = bus_req_i.we ? '0 : rd_word_i;  // Writes answer with zero

    // ----------------------------------------------------------------------
    // Response return path
    // ----------------------------------------------------------------------
    stream_skid #(
        .payload_t (data_t)
    ) u_rsp_skid (
        .seq         (seq),
        .rst_n_i     (rst_n_i),
        .in_data_i   (rsp_in),
        .in_valid_i  (gnt_o),
        .in_ready_o  (rsp_ready),
        .out_data_o  (rsp_out),
        .out_valid_o (rvalid_o),
        .out_ready_i (rready_i)
    );

    assign rsp_o.rdata = rsp_out;

endmodule

// File: verilog/din_mailbox.sv
`timescale 1ns/1ps

module din_mailbox #(
    parameter int DIN_WORDS = 3
) (
    input  logic                                          seq,
    input  logic                                          rst_n_i,

    input  logic [DIN_WORDS*mbx_cfg_pkg::DATA_WIDTH-1:0]  din_i,
    input  logic                                          din_valid_i,
    output logic                                          din_ready_o,

    input  mbx_bus_pkg::word_acc_t                        rd_acc_i,
    output mbx_cfg_pkg::data_t                            rd_word_o,
    output logic                                          din_full_o
);
    import mbx_cfg_pkg::*;
    import mbx_bus_pkg::*;

    localparam idx_t LAST_IDX = idx_t'(DIN_WORDS - 1);

    data_t [DIN_WORDS-1:0] frame_q;             // Word 0 in the low bits
    logic                  full_q;

    logic din_take;
    logic last_read;

    assign din_ready_o = !full_q;
    assign din_full_o  = full_q;

    assign din_take  = din_valid_i && din_ready_o;
    assign last_read = rd_acc_i.fire && (rd_acc_i.idx == LAST_IDX);

    // Addressed word, zero past the end of the frame
    always_comb begin
        rd_word_o = '0;
        if (rd_acc_i.idx < idx_t'(DIN_WORDS)) begin
            rd_word_o = frame_q[rd_acc_i.idx];
        end
    end

    always_ff @(posedge seq) begin
        if (din_take) begin
            frame_q <= din_i;
        end
    end

    // ----------------------------------------------------------------------
    // Full flag, set by din and cleared by the last-word read
    // ----------------------------------------------------------------------
    always_ff @(posedge seq) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (din_take) begin
            full_q <= 1'b1;
        end else if (last_read) begin
            full_q <= 1'b0;                     // Mailbox free again
        end
    end

endmodule

// File: verilog/dout_mailbox.sv
`timescale 1ns/1ps

module dout_mailbox #(
    parameter int DOUT_WORDS = 2
) (
    input  logic                                          seq,
    input  logic                                          rst_n_i,

    input  mbx_bus_pkg::word_acc_t                        wr_acc_i,
    output logic                                          frame_busy_o,

    output logic [DOUT_WORDS*mbx_cfg_pkg::DATA_WIDTH-1:0] dout_o,
    output logic                                          dout_valid_o,
    input  logic                                          dout_ready_i
);
    import mbx_cfg_pkg::*;
    import mbx_bus_pkg::*;

    localparam int   FRAME_WIDTH = DOUT_WORDS * DATA_WIDTH;
    localparam idx_t LAST_IDX    = idx_t'(DOUT_WORDS - 1);

    typedef logic [FRAME_WIDTH-1:0] frame_t;

    data_t [DOUT_WORDS-1:0] asm_q;              // Assembly register
    data_t [DOUT_WORDS-1:0] asm_d;

    logic push;

    // Merge the current write so the last word goes out in the same cycle
    always_comb begin
        asm_d = asm_q;
        if (wr_acc_i.fire && (wr_acc_i.idx < idx_t'(DOUT_WORDS))) begin
            asm_d[wr_acc_i.idx] = wr_acc_i.wdata;
        end
    end

    always_ff @(posedge seq) begin
        if (wr_acc_i.fire) begin
            asm_q <= asm_d;
        end
    end

    assign push = wr_acc_i.fire && (wr_acc_i.idx == LAST_IDX);

    // ----------------------------------------------------------------------
    // Outbound register stage
    // ----------------------------------------------------------------------
    stream_skid #(
        .payload_t (frame_t)
    ) u_skid (
        .seq         (seq),
        .rst_n_i     (rst_n_i),
        .in_data_i   (frame_t'(asm_d)),
        .in_valid_i  (push),
        .in_ready_o  (),
        .out_data_o  (dout_o),
        .out_valid_o (dout_valid_o),
        .out_ready_i (dout_ready_i)
    );

    // Busy until the finished frame has been taken downstream
    assign frame_busy_o = dout_valid_o;

endmodule

// File: verilog/mbx_bus_pkg.sv
package mbx_bus_pkg;

    // ----------------------------------------------------------------------
    // Word index inside a mailbox frame
    // ----------------------------------------------------------------------
    localparam int IDX_WIDTH = 8;               // Frames up to 255 words

    typedef logic [IDX_WIDTH-1:0] idx_t;

    // ----------------------------------------------------------------------
    // Processor bus, request side
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic               req;                // Access request
        logic               we;                 // Write when high
        mbx_cfg_pkg::addr_t addr;               // Byte address
        mbx_cfg_pkg::data_t wdata;              // Whole-word write data
    } bus_req_t;

    // Response beat, one per granted access
    typedef struct packed {
        mbx_cfg_pkg::data_t rdata;              // Zero for writes
    } bus_rsp_t;

    // ----------------------------------------------------------------------
    // Granted access as handed to a mailbox
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic               fire;               // Single-cycle accept strobe
        idx_t               idx;                // Decoded word index
        mbx_cfg_pkg::data_t wdata;              // Used by writes only
    } word_acc_t;

endpackage

// File: verilog/mbx_cfg_pkg.sv
package mbx_cfg_pkg;

    // ----------------------------------------------------------------------
    // Bus geometry
    // ----------------------------------------------------------------------
    localparam int DATA_WIDTH = 32;             // One bus word
    localparam int ADDR_WIDTH = 32;             // Byte address
    localparam int BYTE_BYTES = DATA_WIDTH / 8; // Bytes per word
    localparam int BYTE_OFS   = $clog2(BYTE_BYTES); // Low address bits below a word

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;

endpackage

// File: verilog/mbx_periph.sv
`timescale 1ns/1ps

module mbx_periph #(
    parameter int DIN_WORDS  = 3,
    parameter int DOUT_WORDS = 2
) (
    input  logic                                          seq,
    input  logic                                          rst_n_i,

    // Processor bus
    input  mbx_bus_pkg::bus_req_t                         bus_req_i,
    output logic                                          gnt_o,
    output mbx_bus_pkg::bus_rsp_t                         rsp_o,
    output logic                                          rvalid_o,
    input  logic                                          rready_i,

    // Inbound stream
    input  logic [DIN_WORDS*mbx_cfg_pkg::DATA_WIDTH-1:0]  din_i,
    input  logic                                          din_valid_i,
    output logic                                          din_ready_o,

    // Outbound stream
    output logic [DOUT_WORDS*mbx_cfg_pkg::DATA_WIDTH-1:0] dout_o,
    output logic                                          dout_valid_o,
    input  logic                                          dout_ready_i
);
    import mbx_cfg_pkg::*;
    import mbx_bus_pkg::*;

    word_acc_t rd_acc;
    word_acc_t wr_acc;
    data_t     rd_word;
    logic      din_full;
    logic      frame_busy;

    // ----------------------------------------------------------------------
    // Mailboxes
    // ----------------------------------------------------------------------
    din_mailbox #(
        .DIN_WORDS (DIN_WORDS)
    ) u_din (
        .seq         (seq),
        .rst_n_i     (rst_n_i),
        .din_i       (din_i),
        .din_valid_i (din_valid_i),
        .din_ready_o (din_ready_o),
        .rd_acc_i    (rd_acc),
        .rd_word_o   (rd_word),
        .din_full_o  (din_full)
    );

    dout_mailbox #(
        .DOUT_WORDS (DOUT_WORDS)
    ) u_dout (
        .seq          (seq),
        .rst_n_i      (rst_n_i),
        .wr_acc_i     (wr_acc),
        .frame_busy_o (frame_busy),
        .dout_o       (dout_o),
        .dout_valid_o (dout_valid_o),
        .dout_ready_i (dout_ready_i)
    );

    // ----------------------------------------------------------------------
    // Bus side
    // ----------------------------------------------------------------------
    bus_responder u_rsp (
        .seq          (seq),
        .rst_n_i      (rst_n_i),
        .bus_req_i    (bus_req_i),
        .gnt_o        (gnt_o),
        .din_full_i   (din_full),
        .frame_busy_i (frame_busy),
        .rd_word_i    (rd_word),
        .rd_acc_o     (rd_acc),
        .wr_acc_o     (wr_acc),
        .rsp_o        (rsp_o),
        .rvalid_o     (rvalid_o),
        .rready_i     (rready_i)
    );

endmodule

// File: verilog/stream_skid.sv
`timescale 1ns/1ps

module stream_skid #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     seq,
    input  logic     rst_n_i,

    input  payload_t in_data_i,
    input  logic     in_valid_i,
    output logic     in_ready_o,

    output payload_t out_data_o,
    output logic     out_valid_o,
    input  logic     out_ready_i
);

    // ----------------------------------------------------------------------
    // Two-slot ring buffer
    // ----------------------------------------------------------------------
    payload_t   slot_q [2];                     // Payload storage
    logic       wr_ptr_q;                       // Next slot to fill
    logic       rd_ptr_q;                       // Oldest beat
    logic [1:0] cnt_q;                          // Occupancy 0..2

    logic push;
    logic pop;

    // Ready only looks at registered occupancy, so no path from out_ready_i
    assign in_ready_o  = (cnt_q != 2'd2);
    assign out_valid_o = (cnt_q != 2'd0);
    assign out_data_o  = slot_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge seq) begin
        if (push) begin
            slot_q[wr_ptr_q] <= in_data_i;      // Payload held without reset
        end
    end

    always_ff @(posedge seq) begin
        if (!rst_n_i) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= !wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= !rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   cnt_q <= cnt_q + 2'd1;
                2'b01:   cnt_q <= cnt_q - 2'd1;
                default: cnt_q <= cnt_q;        // Idle or pass-through
            endcase
        end
    end

endmodule

// File: vlog.f
verilog/mbx_cfg_pkg.sv
verilog/mbx_bus_pkg.sv
verilog/stream_skid.sv
verilog/din_mailbox.sv
verilog/dout_mailbox.sv
verilog/bus_responder.sv
verilog/mbx_periph.sv
sim/mbx_periph_props.sv
sim/mbx_periph_tb.sv
